//--- riscv_pkg.sv
/*
 * RV32I core package
 * Widths, opcode values, ALU and branch encodings and the stage structs
 */
`default_nettype none

package riscv_pkg;

  localparam int XLEN        = 32;
  localparam int NB_REG_BITS = 5;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [NB_REG_BITS-1:0] reg_adr_t;
  typedef logic [31:0]            instr_t;

  // --------------------------------------------------
  // Opcode field values
  // --------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
  } alu_op_e;

  // ALWAYS covers JAL and JALR
  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
  } branch_cond_e;

  // --------------------------------------------------
  // Stage registers
  // --------------------------------------------------
  typedef struct packed {
    logic   valid;
    xlen_t  pc;
    instr_t instr;
  } fetch_t;

  typedef struct packed {
    logic         valid;
    xlen_t        pc;
    reg_adr_t     rd;
    logic         rd_wr;
    xlen_t        op_a;
    xlen_t        op_b;
    alu_op_e      alu_op;
    branch_cond_e br_cond;
    xlen_t        rs1_val;
    xlen_t        rs2_val;
    xlen_t        imm;
    logic         is_jalr;
  } dec_t;

  // valid means the instruction retired
  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    logic     wr;
    reg_adr_t rd;
    xlen_t    data;
  } wbk_t;

endpackage

`default_nettype wire

//--- ifetch.sv
/*
 * Instruction fetch
 * Holds the pc, selects the next fetch address and registers the fetched word
 */
`timescale 1ns/10ps
`default_nettype none

module ifetch (
  input  wire logic             clk,
  input  wire logic             reset_n,
  input  riscv_pkg::xlen_t      reset_adr_i,
  input  wire logic             redirect_v_i,
  input  riscv_pkg::xlen_t      redirect_pc_i,
  input  riscv_pkg::instr_t     icache_instr_i,
  output riscv_pkg::xlen_t      icache_adr_o,
  output riscv_pkg::fetch_t     fetch_o
);

  riscv_pkg::xlen_t  pc_q;
  riscv_pkg::fetch_t fetch_q;

  // Redirect target goes out in the same cycle as the pulse
  assign icache_adr_o = redirect_v_i ? redirect_pc_i : pc_q;

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      pc_q    <= reset_adr_i;
      fetch_q <= '0;
    end else begin
      pc_q          <= icache_adr_o + riscv_pkg::xlen_t'(4);
      fetch_q.valid <= 1'b1;
      fetch_q.pc    <= icache_adr_o;
      fetch_q.instr <= icache_instr_i;
    end
  end

  assign fetch_o = fetch_q;

  a_pc_aligned : assert property (@(posedge clk) disable iff (!reset_n)
    icache_adr_o[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- decode.sv
/*
 * Decode stage
 * Field split, immediates, operand selection with forwarding, decode register
 */
`timescale 1ns/10ps
`default_nettype none

module decode (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  riscv_pkg::fetch_t    fetch_i,
  input  wire logic            redirect_v_i,
  output riscv_pkg::reg_adr_t  rs1_adr_o,
  output riscv_pkg::reg_adr_t  rs2_adr_o,
  input  riscv_pkg::xlen_t     rs1_data_i,
  input  riscv_pkg::xlen_t     rs2_data_i,
  input  riscv_pkg::wbk_t      exe_fwd_i,
  input  riscv_pkg::wbk_t      wbk_i,
  output riscv_pkg::dec_t      dec_o
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  riscv_pkg::reg_adr_t rd;
  riscv_pkg::xlen_t    imm_i, imm_u, imm_j, imm_b;
  riscv_pkg::xlen_t    rs1_val, rs2_val;
  riscv_pkg::alu_op_e  alu_op_f3;
  logic                wr_sel;
  riscv_pkg::dec_t     dec_d, dec_q;

  assign opcode    = fetch_i.instr[6:0];
  assign rd        = fetch_i.instr[11:7];
  assign funct3    = fetch_i.instr[14:12];
  assign rs1_adr_o = fetch_i.instr[19:15];
  assign rs2_adr_o = fetch_i.instr[24:20];
  assign funct7    = fetch_i.instr[31:25];

  assign imm_i = {{20{fetch_i.instr[31]}}, fetch_i.instr[31:20]};
  assign imm_u = {fetch_i.instr[31:12], 12'b0};
  assign imm_j = {{12{fetch_i.instr[31]}}, fetch_i.instr[19:12], fetch_i.instr[20],
                  fetch_i.instr[30:21], 1'b0};
  assign imm_b = {{20{fetch_i.instr[31]}}, fetch_i.instr[7], fetch_i.instr[30:25],
                  fetch_i.instr[11:8], 1'b0};

  // --------------------------------------------------
  // Forwarding, youngest producer wins
  // --------------------------------------------------
  function automatic riscv_pkg::xlen_t fwd_value(
    input riscv_pkg::reg_adr_t adr,
    input riscv_pkg::xlen_t    rf_data,
    input riscv_pkg::wbk_t     exe,
    input riscv_pkg::wbk_t     wbk
  );
    if (exe.valid && exe.wr && exe.rd == adr) return exe.data;
    if (wbk.valid && wbk.wr && wbk.rd == adr) return wbk.data;
    return rf_data;
  endfunction

  // wr is never set for x0, so x0 falls through to the regfile
  assign rs1_val = fwd_value(rs1_adr_o, rs1_data_i, exe_fwd_i, wbk_i);
  assign rs2_val = fwd_value(rs2_adr_o, rs2_data_i, exe_fwd_i, wbk_i);

  always_comb begin
    case (funct3)
      3'b000:  alu_op_f3 = (opcode == riscv_pkg::OPC_OP && funct7[5]) ? riscv_pkg::ALU_SUB
                                                                       : riscv_pkg::ALU_ADD;
      3'b001:  alu_op_f3 = riscv_pkg::ALU_SLL;
      3'b010:  alu_op_f3 = riscv_pkg::ALU_SLT;
      3'b011:  alu_op_f3 = riscv_pkg::ALU_SLTU;
      3'b100:  alu_op_f3 = riscv_pkg::ALU_XOR;
      3'b101:  alu_op_f3 = funct7[5] ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
      3'b110:  alu_op_f3 = riscv_pkg::ALU_OR;
      default: alu_op_f3 = riscv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    dec_d.valid   = fetch_i.valid;
    dec_d.pc      = fetch_i.pc;
    dec_d.rd      = rd;
    dec_d.op_a    = rs1_val;
    dec_d.op_b    = rs2_val;
    dec_d.alu_op  = riscv_pkg::ALU_ADD;
    dec_d.br_cond = riscv_pkg::BR_NONE;
    dec_d.rs1_val = rs1_val;
    dec_d.rs2_val = rs2_val;
    dec_d.imm     = imm_i;
    dec_d.is_jalr = 1'b0;
    wr_sel        = 1'b0;
    case (opcode)
      riscv_pkg::OPC_OP: begin
        wr_sel       = 1'b1;
        dec_d.alu_op = alu_op_f3;
      end
      riscv_pkg::OPC_OP_IMM: begin
        wr_sel       = 1'b1;
        dec_d.alu_op = alu_op_f3;
        dec_d.op_b   = imm_i;
      end
      riscv_pkg::OPC_LUI: begin
        wr_sel     = 1'b1;
        dec_d.op_a = '0;
        dec_d.op_b = imm_u;
      end
      riscv_pkg::OPC_AUIPC: begin
        wr_sel     = 1'b1;
        dec_d.op_a = fetch_i.pc;
        dec_d.op_b = imm_u;
      end
      riscv_pkg::OPC_JAL: begin
        wr_sel        = 1'b1;
        dec_d.br_cond = riscv_pkg::BR_ALWAYS;
        dec_d.op_a    = fetch_i.pc;
        dec_d.op_b    = imm_j;
        dec_d.imm     = imm_j;
      end
      riscv_pkg::OPC_JALR: begin
        wr_sel        = 1'b1;
        dec_d.br_cond = riscv_pkg::BR_ALWAYS;
        dec_d.op_b    = imm_i;
        dec_d.is_jalr = 1'b1;
      end
      riscv_pkg::OPC_BRANCH: begin
        dec_d.imm = imm_b;
        case (funct3)
          3'b000:  dec_d.br_cond = riscv_pkg::BR_EQ;
          3'b001:  dec_d.br_cond = riscv_pkg::BR_NE;
          3'b100:  dec_d.br_cond = riscv_pkg::BR_LT;
          3'b101:  dec_d.br_cond = riscv_pkg::BR_GE;
          3'b110:  dec_d.br_cond = riscv_pkg::BR_LTU;
          3'b111:  dec_d.br_cond = riscv_pkg::BR_GEU;
          default: dec_d.br_cond = riscv_pkg::BR_NONE;
        endcase
      end
      // Anything else retires as a no-op
      default: wr_sel = 1'b0;
    endcase
    dec_d.rd_wr = wr_sel && (rd != '0);
  end

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      dec_q <= '0;
    end else begin
      dec_q       <= dec_d;
      dec_q.valid <= dec_d.valid && !redirect_v_i;
    end
  end

  assign dec_o = dec_q;

endmodule

`default_nettype wire

//--- regfile.sv
/*
 * Register file
 * x1..x31, two combinational read ports, one write port from writeback
 */
`timescale 1ns/10ps
`default_nettype none

module regfile (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  riscv_pkg::reg_adr_t  rs1_adr_i,
  input  riscv_pkg::reg_adr_t  rs2_adr_i,
  output riscv_pkg::xlen_t     rs1_data_o,
  output riscv_pkg::xlen_t     rs2_data_o,
  input  riscv_pkg::wbk_t      wbk_i
);

  // No storage behind x0
  riscv_pkg::xlen_t regs_q [1:31];

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wbk_i.valid && wbk_i.wr && wbk_i.rd != '0) begin
      regs_q[wbk_i.rd] <= wbk_i.data;
    end
  end

  assign rs1_data_o = (rs1_adr_i == '0) ? '0 : regs_q[rs1_adr_i];
  assign rs2_data_o = (rs2_adr_i == '0) ? '0 : regs_q[rs2_adr_i];

  // Decode never flags a write to x0, which keeps forwarded x0 reads at zero
  a_no_x0_write : assert property (@(posedge clk) disable iff (!reset_n)
    wbk_i.valid && wbk_i.wr |-> wbk_i.rd != '0);

endmodule

`default_nettype wire

//--- execute.sv
/*
 * Execute stage
 * ALU, branch resolution, writeback register and redirect pulse
 */
`timescale 1ns/10ps
`default_nettype none

module execute (
  input  wire logic         clk,
  input  wire logic         reset_n,
  input  riscv_pkg::dec_t   dec_i,
  output riscv_pkg::wbk_t   exe_fwd_o,
  output riscv_pkg::wbk_t   wbk_o,
  output logic              redirect_v_o,
  output riscv_pkg::xlen_t  redirect_pc_o
);

  riscv_pkg::xlen_t alu_res;
  riscv_pkg::xlen_t jalr_sum;
  riscv_pkg::xlen_t target;
  logic             taken;
  riscv_pkg::wbk_t  wbk_q;
  logic             redirect_v_q;
  riscv_pkg::xlen_t redirect_pc_q;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (dec_i.alu_op)
      riscv_pkg::ALU_SUB:  alu_res = dec_i.op_a - dec_i.op_b;
      riscv_pkg::ALU_AND:  alu_res = dec_i.op_a & dec_i.op_b;
      riscv_pkg::ALU_OR:   alu_res = dec_i.op_a | dec_i.op_b;
      riscv_pkg::ALU_XOR:  alu_res = dec_i.op_a ^ dec_i.op_b;
      riscv_pkg::ALU_SLT:  alu_res = riscv_pkg::xlen_t'($signed(dec_i.op_a) < $signed(dec_i.op_b));
      riscv_pkg::ALU_SLTU: alu_res = riscv_pkg::xlen_t'(dec_i.op_a < dec_i.op_b);
      riscv_pkg::ALU_SLL:  alu_res = dec_i.op_a << dec_i.op_b[4:0];
      riscv_pkg::ALU_SRL:  alu_res = dec_i.op_a >> dec_i.op_b[4:0];
      riscv_pkg::ALU_SRA:  alu_res = $signed(dec_i.op_a) >>> dec_i.op_b[4:0];
      default:             alu_res = dec_i.op_a + dec_i.op_b;
    endcase
  end

  // --------------------------------------------------
  // Branch resolution
  // --------------------------------------------------
  always_comb begin
    case (dec_i.br_cond)
      riscv_pkg::BR_EQ:     taken = dec_i.rs1_val == dec_i.rs2_val;
      riscv_pkg::BR_NE:     taken = dec_i.rs1_val != dec_i.rs2_val;
      riscv_pkg::BR_LT:     taken = $signed(dec_i.rs1_val) < $signed(dec_i.rs2_val);
      riscv_pkg::BR_GE:     taken = $signed(dec_i.rs1_val) >= $signed(dec_i.rs2_val);
      riscv_pkg::BR_LTU:    taken = dec_i.rs1_val < dec_i.rs2_val;
      riscv_pkg::BR_GEU:    taken = dec_i.rs1_val >= dec_i.rs2_val;
      riscv_pkg::BR_ALWAYS: taken = 1'b1;
      default:              taken = 1'b0;
    endcase
  end

  assign jalr_sum = dec_i.rs1_val + dec_i.imm;
  assign target   = dec_i.is_jalr ? {jalr_sum[31:1], 1'b0} : dec_i.pc + dec_i.imm;

  // The slot right behind a taken branch is dead
  assign exe_fwd_o.valid = dec_i.valid && !redirect_v_q;
  assign exe_fwd_o.pc    = dec_i.pc;
  assign exe_fwd_o.wr    = dec_i.rd_wr;
  assign exe_fwd_o.rd    = dec_i.rd;
  assign exe_fwd_o.data  = (dec_i.br_cond == riscv_pkg::BR_ALWAYS)
                         ? dec_i.pc + riscv_pkg::xlen_t'(4) : alu_res;

  always_ff @(posedge clk, negedge reset_n) begin
    if (!reset_n) begin
      wbk_q        <= '0;
      redirect_v_q <= 1'b0;
    end else begin
      wbk_q        <= exe_fwd_o;
      redirect_v_q <= exe_fwd_o.valid && taken;
    end
  end

  always_ff @(posedge clk) begin
    redirect_pc_q <= target;
  end

  assign wbk_o         = wbk_q;
  assign redirect_v_o  = redirect_v_q;
  assign redirect_pc_o = redirect_pc_q;

  // Both shadow slots are squashed, so redirects lie at least three cycles apart
  a_redirect_pulse : assert property (@(posedge clk) disable iff (!reset_n)
    redirect_v_o |-> !$past(redirect_v_o) && !$past(redirect_v_o, 2));

endmodule

`default_nettype wire

//--- core.sv
/*
 * RV32I core top level
 * Fetch, decode, execute and register file, with a retire port
 */
`timescale 1ns/10ps
`default_nettype none

module core (
  input  wire logic            clk,
  input  wire logic            reset_n,
  input  riscv_pkg::xlen_t     reset_adr_i,
  output riscv_pkg::xlen_t     icache_adr_o,
  input  riscv_pkg::instr_t    icache_instr_i,
  output logic                 retire_v_o,
  output riscv_pkg::xlen_t     retire_pc_o,
  output logic                 retire_wr_o,
  output riscv_pkg::reg_adr_t  retire_rd_o,
  output riscv_pkg::xlen_t     retire_data_o
);

  // --------------------------------------------------
  // Stage to stage wires, named after the source stage
  // --------------------------------------------------
  riscv_pkg::fetch_t   if__fetch;
  riscv_pkg::reg_adr_t dec__rs1_adr, dec__rs2_adr;
  riscv_pkg::xlen_t    rf__rs1_data, rf__rs2_data;
  riscv_pkg::dec_t     dec__dec;
  riscv_pkg::wbk_t     exe__fwd, exe__wbk;
  logic                exe__redirect_v;
  riscv_pkg::xlen_t    exe__redirect_pc;

  ifetch u_ifetch (
    .clk            (clk),
    .reset_n        (reset_n),
    .reset_adr_i    (reset_adr_i),
    .redirect_v_i   (exe__redirect_v),
    .redirect_pc_i  (exe__redirect_pc),
    .icache_instr_i (icache_instr_i),
    .icache_adr_o   (icache_adr_o),
    .fetch_o        (if__fetch)
  );

  decode u_decode (
    .clk          (clk),
    .reset_n      (reset_n),
    .fetch_i      (if__fetch),
    .redirect_v_i (exe__redirect_v),
    .rs1_adr_o    (dec__rs1_adr),
    .rs2_adr_o    (dec__rs2_adr),
    .rs1_data_i   (rf__rs1_data),
    .rs2_data_i   (rf__rs2_data),
    .exe_fwd_i    (exe__fwd),
    .wbk_i        (exe__wbk),
    .dec_o        (dec__dec)
  );

  regfile u_regfile (
    .clk        (clk),
    .reset_n    (reset_n),
    .rs1_adr_i  (dec__rs1_adr),
    .rs2_adr_i  (dec__rs2_adr),
    .rs1_data_o (rf__rs1_data),
    .rs2_data_o (rf__rs2_data),
    .wbk_i      (exe__wbk)
  );

  execute u_execute (
    .clk           (clk),
    .reset_n       (reset_n),
    .dec_i         (dec__dec),
    .exe_fwd_o     (exe__fwd),
    .wbk_o         (exe__wbk),
    .redirect_v_o  (exe__redirect_v),
    .redirect_pc_o (exe__redirect_pc)
  );

  // Retire port straight from the writeback register
  assign retire_v_o    = exe__wbk.valid;
  assign retire_pc_o   = exe__wbk.pc;
  assign retire_wr_o   = exe__wbk.wr;
  assign retire_rd_o   = exe__wbk.rd;
  assign retire_data_o = exe__wbk.data;

endmodule

`default_nettype wire

//--- tb_core.sv
/*
 * Testbench for the RV32I core
 * Instruction memory model loaded from the vectors file, in-order retire checker
 */
`timescale 1ns/10ps
`default_nettype none

module tb_core;

  localparam riscv_pkg::xlen_t  RESET_ADR    = 32'h0000_0100;
  localparam riscv_pkg::instr_t NOP_INSTR    = 32'h0000_0013;
  localparam int                HALF_PERIOD  = 2;
  localparam int                RESET_CYCLES = 4;

  logic                clk;
  logic                reset_n;
  riscv_pkg::xlen_t    reset_adr;
  riscv_pkg::xlen_t    icache_adr;
  riscv_pkg::instr_t   icache_instr;
  logic                retire_v;
  riscv_pkg::xlen_t    retire_pc;
  logic                retire_wr;
  riscv_pkg::reg_adr_t retire_rd;
  riscv_pkg::xlen_t    retire_data;

  // Program image, addresses outside it read as NOP
  riscv_pkg::instr_t imem [riscv_pkg::xlen_t];
  riscv_pkg::wbk_t   expected_q [$];
  int                retire_idx;
  logic              vectors_loaded;

  core u_dut (
    .clk            (clk),
    .reset_n        (reset_n),
    .reset_adr_i    (reset_adr),
    .icache_adr_o   (icache_adr),
    .icache_instr_i (icache_instr),
    .retire_v_o     (retire_v),
    .retire_pc_o    (retire_pc),
    .retire_wr_o    (retire_wr),
    .retire_rd_o    (retire_rd),
    .retire_data_o  (retire_data)
  );

  always #(HALF_PERIOD) clk = ~clk;

  task automatic fail_run(input string why);
    $display("Test failed");
    $fatal(1, "%s", why);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("error %s expected %h actual %h", name, expected, actual);
      fail_run("retired instruction differs from the expected one");
    end
  endtask

  // --------------------------------------------------
  // Vectors file, I lines fill memory, E lines queue
  // --------------------------------------------------
  task automatic load_vectors();
    int              fd;
    int              c;
    int              n;
    logic [31:0]     f0, f1, f2, f3;
    riscv_pkg::wbk_t entry;
    fd = $fopen("core_vectors.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open core_vectors.txt");
    end
    while (!$feof(fd)) begin
      c = $fgetc(fd);
      if (c == int'("I")) begin
        n = $fscanf(fd, "%h %h", f0, f1);
        if (n != 2) begin
          fail_run("malformed program line in core_vectors.txt");
        end
        imem[f0] = f1;
      end else if (c == int'("E")) begin
        n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
        if (n != 4) begin
          fail_run("malformed retire line in core_vectors.txt");
        end
        entry.valid = 1'b1;
        entry.pc    = f0;
        entry.wr    = f1[0];
        entry.rd    = f2[4:0];
        entry.data  = f3;
        expected_q.push_back(entry);
      end else if (c == int'("#")) begin
        // Comment runs to the end of the line
        while (c != int'("\n") && c != -1) begin
          c = $fgetc(fd);
        end
      end
    end
    $fclose(fd);
    if (expected_q.size() == 0) begin
      fail_run("core_vectors.txt holds no expected retires");
    end
  endtask

  function automatic riscv_pkg::instr_t fetch_word(input riscv_pkg::xlen_t adr);
    if (imem.exists(adr)) begin
      return imem[adr];
    end
    return NOP_INSTR;
  endfunction

  task automatic check_retire();
    riscv_pkg::wbk_t want;
    string           tag;
    want = expected_q[retire_idx];
    tag  = $sformatf("retire %0d", retire_idx);
    check_value({tag, " pc"}, want.pc, retire_pc);
    check_value({tag, " wr"}, {31'b0, want.wr}, {31'b0, retire_wr});
    // rd and data only mean something for a register write
    if (want.wr) begin
      check_value({tag, " rd"}, {27'b0, want.rd}, {27'b0, retire_rd});
      check_value({tag, " data"}, want.data, retire_data);
    end
    retire_idx++;
  endtask

  // --------------------------------------------------
  // Stimulus, checker and watchdog
  // --------------------------------------------------
  initial begin
    clk            = 1'b0;
    reset_n        = 1'b0;
    reset_adr      = RESET_ADR;
    icache_instr   = NOP_INSTR;
    retire_idx     = 0;
    vectors_loaded = 1'b0;
    load_vectors();
    vectors_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #0.5;
    reset_n = 1'b1;
  end

  // Memory answers the fetch address of the current cycle
  always @(posedge clk) begin
    #0.5;
    icache_instr = fetch_word(icache_adr);
  end

  always @(posedge clk) begin
    if (reset_n && retire_v) begin
      check_retire();
      if (retire_idx == expected_q.size()) begin
        $display("Test completed successfully");
        $finish;
      end
    end
  end

  initial begin
    wait (vectors_loaded);
    repeat (20 * expected_q.size() + 50) @(posedge clk);
    fail_run("watchdog timeout before all expected retires were seen");
  end

endmodule

`default_nettype wire

//--- core_vectors.txt
# I address word          program image in hex
# E pc wr rd data         expected retires in order, rd and data ignored when wr is 0
I 00000100 00500093  # addi x1, x0, 5
I 00000104 FFD00113  # addi x2, x0, -3
I 00000108 002081B3  # add  x3, x1, x2
I 0000010C 40208233  # sub  x4, x1, x2
I 00000110 001122B3  # slt  x5, x2, x1
I 00000114 00113333  # sltu x6, x2, x1
I 00000118 0041C3B3  # xor  x7, x3, x4
I 0000011C 0053E433  # or   x8, x7, x5
I 00000120 0F017493  # andi x9, x2, 0xf0
I 00000124 00409513  # slli x10, x1, 4
I 00000128 40115593  # srai x11, x2, 1
I 0000012C 01C15613  # srli x12, x2, 28
I 00000130 123456B7  # lui  x13, 0x12345
I 00000134 00001717  # auipc x14, 1
I 00000138 00708013  # addi x0, x1, 7
I 0000013C 00208863  # beq  x1, x2, +16 not taken
I 00000140 00209863  # bne  x1, x2, +16 taken
I 00000150 010007EF  # jal  x15, +16
I 00000160 18100813  # addi x16, x0, 0x181
I 00000164 004808E7  # jalr x17, 4(x16)
I 00000184 00F88933  # add  x18, x17, x15
E 00000100 1 01 00000005
E 00000104 1 02 FFFFFFFD
E 00000108 1 03 00000002
E 0000010C 1 04 00000008
E 00000110 1 05 00000001
E 00000114 1 06 00000000
E 00000118 1 07 0000000A
E 0000011C 1 08 0000000B
E 00000120 1 09 000000F0
E 00000124 1 0A 00000050
E 00000128 1 0B FFFFFFFE
E 0000012C 1 0C 0000000F
E 00000130 1 0D 12345000
E 00000134 1 0E 00001134
E 00000138 0 00 00000000
E 0000013C 0 00 00000000
E 00000140 0 00 00000000
E 00000150 1 0F 00000154
E 00000160 1 10 00000181
E 00000164 1 11 00000168
E 00000184 1 12 000002BC

//--- vlog.f
riscv_pkg.sv
ifetch.sv
decode.sv
regfile.sv
execute.sv
core.sv
tb_core.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_core
FILELIST  = vlog.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
